//--- fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Halfword entries in the instruction ring, a power of two of at least 16.
`define FETCH_BUFFER_DEPTH 16

// First fetch address after reset.
`define FETCH_RESET_PC 32'h0000_1000

// Above this occupancy fetch holds off, leaving room for one more response.
`define FETCH_STALL_LEVEL (`FETCH_BUFFER_DEPTH - 8)

`endif

//--- fetch_pkg.sv
package fetch_pkg;

  // ********************
  // Fetch controller
  // ********************

  typedef enum logic [1:0] {
    fetch_idle    = 2'd0, // Waiting for room in the buffer.
    fetch_request = 2'd1, // Request presented to memory.
    fetch_wait    = 2'd2  // Response outstanding.
  } fetch_state_t;

  // ********************
  // Realigned instruction
  // ********************

  // A 16-bit instruction keeps zero in the upper half of instr.
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
  } slot_t;

endpackage

//--- fetch_ctrl.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_ctrl import fetch_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  output logic        mem_req_valid,
  output logic [31:0] mem_req_addr,
  input  logic        mem_req_ready,
  input  logic        mem_resp_valid,
  input  logic        redirect,
  input  logic [31:0] redirect_pc,
  input  logic        buf_stall,
  output logic        buf_fill_valid,
  output logic [31:0] buf_fill_pc,
  output logic        flush
);

  fetch_state_t state;
  fetch_state_t state_next;
  logic [31:0]  fetch_pc;
  logic [31:0]  inflight_pc;
  logic         drop;
  logic         req_fire;

  assign req_fire = mem_req_valid && mem_req_ready;

  always_comb begin
    state_next = state;
    case (state)
      fetch_idle: begin
        if (!buf_stall) begin
          state_next = fetch_request;
        end
      end
      fetch_request: begin
        if (req_fire) begin
          state_next = fetch_wait;
        end
      end
      fetch_wait: begin
        if (mem_resp_valid) begin
          state_next = buf_stall ? fetch_idle : fetch_request;
        end
      end
      default: begin
        state_next = fetch_idle;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state    <= fetch_idle;
      fetch_pc <= `FETCH_RESET_PC;
      drop     <= 1'b0;
    end else begin
      state <= state_next;
      if (redirect) begin
        fetch_pc <= {redirect_pc[31:3], 3'b000};
        // A request still in flight now belongs to the old stream.
        drop     <= (state == fetch_wait && !mem_resp_valid) || req_fire;
      end else begin
        if (req_fire) begin
          fetch_pc <= fetch_pc + 32'd8;
        end
        if (mem_resp_valid) begin
          drop <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req_fire) begin
      inflight_pc <= mem_req_addr;
    end
  end

  assign mem_req_valid  = (state == fetch_request);
  assign mem_req_addr   = fetch_pc;
  assign buf_fill_valid = mem_resp_valid && !drop; // Stale responses never reach the buffer.
  assign buf_fill_pc    = inflight_pc;
  assign flush          = redirect;

  a_req_stable: assert property (@(posedge clock) disable iff (!reset)
    mem_req_valid && !mem_req_ready && !redirect |=>
      mem_req_valid && $stable(mem_req_addr))
    else $error("mem_req_addr changed before the request transferred");

endmodule

//--- instr_buffer.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module instr_buffer import fetch_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        flush,
  input  logic        fill_valid,
  input  logic [31:0] fill_pc,
  input  logic [63:0] fill_data,
  input  logic        hold,
  output logic        stall,
  output logic        out_ready0,
  output logic [31:0] out_pc0,
  output logic [31:0] out_instr0,
  output logic        out_ready1,
  output logic [31:0] out_pc1,
  output logic [31:0] out_instr1
);

  localparam int depth = `FETCH_BUFFER_DEPTH;
  localparam int idx_w = $clog2(depth);

  logic [15:0]      ring_half [depth];
  logic [31:0]      ring_pc [depth];
  logic [idx_w-1:0] wr_idx;
  logic [idx_w-1:0] rd_idx;
  logic [idx_w:0]   count;

  logic [15:0] half [4];
  logic [31:0] half_pc [3];
  logic        comp0;
  logic        comp1;
  logic [15:0] head1;
  logic [15:0] tail1;
  logic [31:0] head1_pc;
  logic [2:0]  len0;
  logic [2:0]  len1;
  logic [2:0]  used;
  logic [2:0]  consume;
  logic [2:0]  fill_add;
  slot_t       slot0;
  slot_t       slot1;

  // ********************
  // Ring storage
  // ********************

  always_ff @(posedge clock) begin
    if (fill_valid && !flush) begin
      for (int i = 0; i < 4; i++) begin
        ring_half[wr_idx + idx_w'(i)] <= fill_data[16*i +: 16];
        ring_pc[wr_idx + idx_w'(i)]   <= fill_pc + 32'(2 * i);
      end
    end
  end

  always_comb begin
    for (int k = 0; k < 4; k++) begin
      half[k] = ring_half[rd_idx + idx_w'(k)];
    end
    for (int k = 0; k < 3; k++) begin
      half_pc[k] = ring_pc[rd_idx + idx_w'(k)];
    end
  end

  // ********************
  // Realignment
  // ********************

  assign comp0    = (half[0][1:0] != 2'b11);
  assign len0     = comp0 ? 3'd1 : 3'd2;
  assign head1    = comp0 ? half[1] : half[2]; // Second instruction starts after the first.
  assign tail1    = comp0 ? half[2] : half[3];
  assign head1_pc = comp0 ? half_pc[1] : half_pc[2];
  assign comp1    = (head1[1:0] != 2'b11);
  assign len1     = comp1 ? 3'd1 : 3'd2;

  // Entries past the count are never examined.
  assign out_ready0 = (count != '0) && (count >= (idx_w+1)'(len0));
  assign out_ready1 = (count != '0) && (count > (idx_w+1)'(len0)) &&
                      (count >= (idx_w+1)'(len0 + len1));

  assign slot0 = '{pc: half_pc[0], instr: comp0 ? {16'h0000, half[0]} : {half[1], half[0]}};
  assign slot1 = '{pc: head1_pc, instr: comp1 ? {16'h0000, head1} : {tail1, head1}};

  assign out_pc0    = slot0.pc;
  assign out_instr0 = slot0.instr;
  assign out_pc1    = slot1.pc;
  assign out_instr1 = slot1.instr;

  always_comb begin
    if (out_ready1) begin
      used = len0 + len1;
    end else if (out_ready0) begin
      used = len0;
    end else begin
      used = 3'd0;
    end
  end

  assign consume  = hold ? 3'd0 : used; // The issue register is full and waiting.
  assign fill_add = fill_valid ? 3'd4 : 3'd0;

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      wr_idx <= '0;
      rd_idx <= '0;
      count  <= '0;
    end else begin
      if (fill_valid) begin
        wr_idx <= wr_idx + idx_w'(4);
      end
      rd_idx <= rd_idx + idx_w'(consume);
      count  <= count + (idx_w+1)'(fill_add) - (idx_w+1)'(consume);
    end
  end

  assign stall = (count > (idx_w+1)'(`FETCH_STALL_LEVEL));

  a_count_bound: assert property (@(posedge clock) disable iff (!reset)
    count <= (idx_w+1)'(depth))
    else $error("instr_buffer holds more halfwords than its depth");

  a_slot_order: assert property (@(posedge clock) disable iff (!reset)
    out_ready1 |-> out_ready0)
    else $error("second slot offered without the first");

endmodule

//--- issue_reg.sv
`timescale 1ns/1ps

module issue_reg import fetch_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        flush,
  input  logic        in_ready0,
  input  logic [31:0] in_pc0,
  input  logic [31:0] in_instr0,
  input  logic        in_ready1,
  input  logic [31:0] in_pc1,
  input  logic [31:0] in_instr1,
  input  logic        issue_ready,
  output logic        hold,
  output logic        issue_valid,
  output logic        issue_pair,
  output logic [31:0] issue_pc0,
  output logic [31:0] issue_instr0,
  output logic [31:0] issue_pc1,
  output logic [31:0] issue_instr1
);

  slot_t entry0;
  slot_t entry1;
  logic  valid0;
  logic  valid1;
  logic  load;

  assign hold = valid0 && !issue_ready;
  assign load = !hold; // Empty, or the current pair leaves this edge.

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      valid0 <= 1'b0;
      valid1 <= 1'b0;
    end else if (load) begin
      valid0 <= in_ready0;
      valid1 <= in_ready1;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      entry0 <= '{pc: in_pc0, instr: in_instr0};
      entry1 <= '{pc: in_pc1, instr: in_instr1};
    end
  end

  assign issue_valid  = valid0;
  assign issue_pair   = valid1;
  assign issue_pc0    = entry0.pc;
  assign issue_instr0 = entry0.instr;
  assign issue_pc1    = entry1.pc;
  assign issue_instr1 = entry1.instr;

  a_issue_stable: assert property (@(posedge clock) disable iff (!reset)
    issue_valid && !issue_ready && !flush |=>
      issue_valid && $stable(issue_pair) && $stable(entry0) && $stable(entry1))
    else $error("issue outputs changed under back-pressure");

endmodule

//--- fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
  input  logic        clock,
  input  logic        reset,
  output logic        mem_req_valid,
  output logic [31:0] mem_req_addr,
  input  logic        mem_req_ready,
  input  logic        mem_resp_valid,
  input  logic [63:0] mem_resp_data,
  input  logic        redirect,
  input  logic [31:0] redirect_pc,
  output logic        issue_valid,
  output logic [31:0] issue_pc0,
  output logic [31:0] issue_instr0,
  output logic        issue_pair,
  output logic [31:0] issue_pc1,
  output logic [31:0] issue_instr1,
  input  logic        issue_ready
);

  logic        buf_fill_valid;
  logic [31:0] buf_fill_pc;
  logic        buf_stall;
  logic        flush;
  logic        hold;
  logic        out_ready0;
  logic [31:0] out_pc0;
  logic [31:0] out_instr0;
  logic        out_ready1;
  logic [31:0] out_pc1;
  logic [31:0] out_instr1;

  fetch_ctrl u_fetch_ctrl (
    .clock          (clock),
    .reset          (reset),
    .mem_req_valid  (mem_req_valid),
    .mem_req_addr   (mem_req_addr),
    .mem_req_ready  (mem_req_ready),
    .mem_resp_valid (mem_resp_valid),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .buf_stall      (buf_stall),
    .buf_fill_valid (buf_fill_valid),
    .buf_fill_pc    (buf_fill_pc),
    .flush          (flush)
  );

  // Response data goes straight into the ring, tagged by the controller.
  instr_buffer u_instr_buffer (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .fill_valid (buf_fill_valid),
    .fill_pc    (buf_fill_pc),
    .fill_data  (mem_resp_data),
    .hold       (hold),
    .stall      (buf_stall),
    .out_ready0 (out_ready0),
    .out_pc0    (out_pc0),
    .out_instr0 (out_instr0),
    .out_ready1 (out_ready1),
    .out_pc1    (out_pc1),
    .out_instr1 (out_instr1)
  );

  issue_reg u_issue_reg (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .in_ready0    (out_ready0),
    .in_pc0       (out_pc0),
    .in_instr0    (out_instr0),
    .in_ready1    (out_ready1),
    .in_pc1       (out_pc1),
    .in_instr1    (out_instr1),
    .issue_ready  (issue_ready),
    .hold         (hold),
    .issue_valid  (issue_valid),
    .issue_pair   (issue_pair),
    .issue_pc0    (issue_pc0),
    .issue_instr0 (issue_instr0),
    .issue_pc1    (issue_pc1),
    .issue_instr1 (issue_instr1)
  );

endmodule

//--- tb_fetch_top.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module tb_fetch_top;

  localparam int num_instr     = 1500;
  localparam int max_cycles    = num_instr * 40 / 3; // About five times the expected run length.
  localparam int mem_halfwords = 32768;

  logic        clock;
  logic        reset;
  logic        mem_req_valid;
  logic [31:0] mem_req_addr;
  logic        mem_req_ready;
  logic        mem_resp_valid;
  logic [63:0] mem_resp_data;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic        issue_valid;
  logic [31:0] issue_pc0;
  logic [31:0] issue_instr0;
  logic        issue_pair;
  logic [31:0] issue_pc1;
  logic [31:0] issue_instr1;
  logic        issue_ready;

  logic [15:0] mem [mem_halfwords];
  int          errors;
  int          checked;
  int          cycles;
  logic        pair_seen;
  logic        first_req_seen;
  logic        fire_seen;
  logic [31:0] req_addr_seen;
  logic [31:0] exp_pc;
  logic [31:0] next_pc;
  logic [31:0] exp_instr;
  logic        held;
  logic        held_pair;
  logic [31:0] held_pc0;
  logic [31:0] held_instr0;
  logic [31:0] held_pc1;
  logic [31:0] held_instr1;

  fetch_top DUT (
    .clock          (clock),
    .reset          (reset),
    .mem_req_valid  (mem_req_valid),
    .mem_req_addr   (mem_req_addr),
    .mem_req_ready  (mem_req_ready),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .issue_valid    (issue_valid),
    .issue_pc0      (issue_pc0),
    .issue_instr0   (issue_instr0),
    .issue_pair     (issue_pair),
    .issue_pc1      (issue_pc1),
    .issue_instr1   (issue_instr1),
    .issue_ready    (issue_ready)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Next instruction of the program that starts at pc.
  function automatic logic [31:0] expected_instr(input logic [31:0] pc,
                                                 output logic [31:0] pc_after);
    logic [15:0] lo;
    logic [15:0] hi;
    lo = mem[pc[15:1]];
    hi = mem[pc[15:1] + 15'd1];
    if (lo[1:0] == 2'b11) begin
      pc_after = pc + 32'd4;
      return {hi, lo};
    end
    pc_after = pc + 32'd2; // Compressed, upper half stays zero.
    return {16'h0000, lo};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      errors++;
      $display("ERR %s got %h expected %h at %0t", name, got, expected, $time);
    end
  endtask

  task automatic end_run;
    $display("Checked %0d instructions, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  task automatic respond(input logic [31:0] addr);
    mem_resp_valid <= 1'b1;
    mem_resp_data  <= {mem[addr[15:1] + 15'd3], mem[addr[15:1] + 15'd2],
                       mem[addr[15:1] + 15'd1], mem[addr[15:1]]};
  endtask

  // ********************
  // Stimulus and memory model
  // ********************

  initial begin
    logic [31:0] r;
    int          delay;
    int          resp_wait;
    int          ready_left;
    logic [31:0] pend_addr;
    r = $urandom(32'hd026c124);
    reset          = 1'b0;
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_data  = '0;
    redirect       = 1'b0;
    redirect_pc    = '0;
    issue_ready    = 1'b0;
    errors         = 0;
    checked        = 0;
    cycles         = 0;
    pair_seen      = 1'b0;
    first_req_seen = 1'b0;
    fire_seen      = 1'b0;
    held           = 1'b0;
    exp_pc         = `FETCH_RESET_PC;
    resp_wait      = 0;
    ready_left     = 0;
    pend_addr      = '0;
    for (int i = 0; i < mem_halfwords; i++) begin
      r = $urandom;
      if (r[16]) begin
        mem[i] = {r[15:2], 2'b11}; // Low half of a 32-bit instruction.
      end else begin
        mem[i] = {r[15:2], (r[1:0] == 2'b11) ? 2'b00 : r[1:0]};
      end
    end
    repeat (8) @(posedge clock);
    reset <= 1'b1;
    forever begin
      @(posedge clock);
      mem_resp_valid <= 1'b0;
      if (resp_wait > 0) begin
        resp_wait--;
        if (resp_wait == 0) begin
          respond(pend_addr);
        end
      end
      if (fire_seen) begin
        delay = $urandom % 4;
        if (delay == 0) begin
          respond(req_addr_seen);
        end else begin
          pend_addr = req_addr_seen;
          resp_wait = delay;
        end
      end
      mem_req_ready <= (($urandom % 4) != 0);
      if (checked < 400) begin
        issue_ready <= 1'b1;
      end else if (ready_left == 0) begin
        r          = $urandom;
        ready_left = r[0] ? 1 + $urandom % 6 : 1 + $urandom % `FETCH_BUFFER_DEPTH;
        issue_ready <= r[0];
      end else begin
        ready_left--;
      end
      redirect <= 1'b0;
      if (checked >= 1000 && ($urandom % 40) == 0) begin
        r = $urandom;
        redirect    <= 1'b1;
        redirect_pc <= {16'h0000, r[15:3], 3'b000};
      end
    end
  end

  // ********************
  // Compare
  // ********************

  always @(negedge clock) begin
    if (!reset) begin
      if (cycles > 0) begin
        check_value("issue_valid", 32'(issue_valid), 32'd0);
        check_value("mem_req_valid", 32'(mem_req_valid), 32'd0);
      end
    end else begin
      if (mem_req_valid && !first_req_seen) begin
        check_value("mem_req_addr", mem_req_addr, `FETCH_RESET_PC);
        first_req_seen = 1'b1;
      end
      if (held) begin
        check_value("issue_valid", 32'(issue_valid), 32'd1);
        check_value("issue_pair", 32'(issue_pair), 32'(held_pair));
        check_value("issue_pc0", issue_pc0, held_pc0);
        check_value("issue_instr0", issue_instr0, held_instr0);
        check_value("issue_pc1", issue_pc1, held_pc1);
        check_value("issue_instr1", issue_instr1, held_instr1);
      end
      if (issue_valid && issue_ready) begin
        exp_instr = expected_instr(exp_pc, next_pc);
        check_value("issue_pc0", issue_pc0, exp_pc);
        check_value("issue_instr0", issue_instr0, exp_instr);
        exp_pc = next_pc;
        checked++;
        if (issue_pair) begin
          pair_seen = 1'b1;
          exp_instr = expected_instr(exp_pc, next_pc);
          check_value("issue_pc1", issue_pc1, exp_pc);
          check_value("issue_instr1", issue_instr1, exp_instr);
          exp_pc = next_pc;
          checked++;
        end
      end
      held        = issue_valid && !issue_ready && !redirect;
      held_pair   = issue_pair;
      held_pc0    = issue_pc0;
      held_instr0 = issue_instr0;
      held_pc1    = issue_pc1;
      held_instr1 = issue_instr1;
      if (redirect) begin
        exp_pc = redirect_pc; // The pair leaving at this edge still belongs to the old stream.
      end
    end
    fire_seen     = mem_req_valid && mem_req_ready;
    req_addr_seen = mem_req_addr;
    if (checked >= num_instr) begin
      if (!pair_seen) begin
        errors++;
        $display("issue_pair was never high during the run");
      end
      end_run();
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= max_cycles) begin
      errors++;
      $display("Timeout after %0d cycles, %0d of %0d instructions checked",
               cycles, checked, num_instr);
      end_run();
    end
  end

endmodule

//--- vlog.f
+incdir+.
fetch_pkg.sv
fetch_ctrl.sv
instr_buffer.sv
issue_reg.sv
fetch_top.sv
tb_fetch_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
